//--- compile.f
pcie_tl_pkg.sv
pcie_tl_regs.sv
pcie_tl_link_init.sv
pcie_tl_dma_rd.sv
pcie_tl_tlp_tx.sv
pcie_tl.sv
tb_pcie_tl_properties.sv
tb_pcie_tl.sv

//--- Bender.yml
package:
  name: pcie_tl

sources:
  - pcie_tl_pkg.sv
  - pcie_tl_regs.sv
  - pcie_tl_link_init.sv
  - pcie_tl_dma_rd.sv
  - pcie_tl_tlp_tx.sv
  - pcie_tl.sv
  - target: test
    files:
      - tb_pcie_tl_properties.sv
      - tb_pcie_tl.sv

//--- tb_pcie_tl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pcie_tl;

    localparam int NUM_VC     = 8;
    localparam int MAX_CYCLES = 20000;  // Whole run takes well under 2000

    logic                           aclk = 1'b0;
    logic                           arst;
    logic                           awvalid_i;
    logic                           wvalid_i;
    pcie_tl_pkg::cpu_aw_t           cpu_aw_i;
    logic                           awready_o;
    logic                           wready_o;
    logic                           bvalid_o;
    logic                           bready_i;
    pcie_tl_pkg::axi_resp_t         bresp_o;
    logic                           arvalid_i;
    pcie_tl_pkg::cpu_ar_t           araddr_i;
    logic                           arready_o;
    logic                           rvalid_o;
    logic                           rready_i;
    pcie_tl_pkg::cpu_r_t            cpu_r_o;
    logic                           mem_arvalid_o;
    logic                           mem_arready_i = 1'b0;
    logic [pcie_tl_pkg::DATA_W-1:0] mem_araddr_o;
    logic                           mem_rvalid_i = 1'b0;
    logic                           mem_rready_o;
    logic [pcie_tl_pkg::DATA_W-1:0] mem_rdata_i = '0;
    logic                           mem_rlast_i = 1'b0;
    logic                           tx_valid_o;
    logic                           tx_ready_i = 1'b1;
    logic [pcie_tl_pkg::DATA_W-1:0] tx_data_o;
    logic                           linkup_i;
    logic [NUM_VC-1:0]              dll_vc_up_i;

    integer      seed         = 34798;
    int          errors       = 0;
    int          checks       = 0;
    int          cycles       = 0;
    int          beat         = 0;
    bit          random_ready = 1'b0;
    logic [31:0] ar_q[$];   // Accepted burst addresses
    logic [31:0] tx_q[$];   // Words seen on TX

    pcie_tl #(.NUM_VC(NUM_VC)) dut_i (.*);

    always #10 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run never completed", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
        return (byte_addr >> 2) ^ 32'hA5A5_0000;
    endfunction

    // Memory model, 16 beat INCR bursts served in order
    always @(posedge aclk) begin
        if (mem_arvalid_o && mem_arready_i) ar_q.push_back(mem_araddr_o);
        if (mem_rvalid_i && mem_rready_o) begin
            if (beat == 15) begin
                beat = 0;
                void'(ar_q.pop_front());
            end else begin
                beat = beat + 1;
            end
        end
        if (ar_q.size() > 0) begin
            mem_rvalid_i <= 1'b1;
            mem_rdata_i  <= mem_word(ar_q[0] + 32'(4 * beat));
            mem_rlast_i  <= beat == 15;
        end else begin
            mem_rvalid_i <= 1'b0;
        end
        mem_arready_i <= !(mem_arvalid_o && mem_arready_i);  // Gap after each AR
    end

    // TX sink
    always @(posedge aclk) begin
        if (tx_valid_o && tx_ready_i) tx_q.push_back(tx_data_o);
        tx_ready_i <= random_ready ? ($random(seed) % 2 != 0) : 1'b1;
    end

    task automatic check_word(input string name, input logic [pcie_tl_pkg::DATA_W-1:0] got,
                              input logic [pcie_tl_pkg::DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input pcie_tl_pkg::axi_resp_t got,
                              input pcie_tl_pkg::axi_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_hdr(input string name, input pcie_tl_pkg::tlp_hdr_t got,
                             input pcie_tl_pkg::tlp_hdr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] data,
                             output pcie_tl_pkg::axi_resp_t resp);
        @(posedge aclk);
        awvalid_i     <= 1'b1;
        wvalid_i      <= 1'b1;
        cpu_aw_i.addr <= addr;
        cpu_aw_i.data <= data;
        @(posedge aclk);
        while (!awready_o) @(posedge aclk);
        check_word("wready_o", 32'(wready_o), 32'h1);  // W taken with AW
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
        @(posedge aclk);
        while (!bvalid_o) @(posedge aclk);
        resp = bresp_o;
        bready_i <= 1'b1;
        @(posedge aclk);
        bready_i <= 1'b0;
    endtask

    task automatic reg_read(input logic [31:0] addr, output pcie_tl_pkg::cpu_r_t r);
        @(posedge aclk);
        arvalid_i     <= 1'b1;
        araddr_i.addr <= addr;
        @(posedge aclk);
        while (!arready_o) @(posedge aclk);
        arvalid_i <= 1'b0;
        @(posedge aclk);
        while (!rvalid_o) @(posedge aclk);
        r = cpu_r_o;
        rready_i <= 1'b1;
        @(posedge aclk);
        rready_i <= 1'b0;
    endtask

    task automatic write_ok(input logic [31:0] addr, input logic [31:0] data,
                            input string name);
        pcie_tl_pkg::axi_resp_t resp;
        reg_write(addr, data, resp);
        check_resp({name, " bresp"}, resp, pcie_tl_pkg::RESP_OKAY);
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp_data,
                               input pcie_tl_pkg::axi_resp_t exp_resp, input string name);
        pcie_tl_pkg::cpu_r_t r;
        reg_read(addr, r);
        check_word({name, " rdata"}, r.data, exp_data);
        check_resp({name, " rresp"}, r.resp, exp_resp);
    endtask

    task automatic reg_readback();
        write_ok(pcie_tl_pkg::REG_TC_VC_MAP, 32'h7654_3210, "tc_vc_map");
        write_ok(pcie_tl_pkg::REG_BAR0_BASE, 32'hC000_1000, "bar0");
        write_ok(pcie_tl_pkg::REG_TX_DESC_LEN, 32'h0000_0140, "desc_len");
        write_ok(pcie_tl_pkg::REG_TX_DESC_ADDR, 32'h0003_2100, "desc_addr");
        read_expect(pcie_tl_pkg::REG_TC_VC_MAP, 32'h7654_3210, pcie_tl_pkg::RESP_OKAY,
                    "tc_vc_map");
        read_expect(pcie_tl_pkg::REG_BAR0_BASE, 32'hC000_1000, pcie_tl_pkg::RESP_OKAY, "bar0");
        read_expect(pcie_tl_pkg::REG_TX_DESC_LEN, 32'h0000_0140, pcie_tl_pkg::RESP_OKAY,
                    "desc_len");
        read_expect(pcie_tl_pkg::REG_TX_DESC_ADDR, 32'h0003_2100, pcie_tl_pkg::RESP_OKAY,
                    "desc_addr");
    endtask

    task automatic unmapped_access();
        pcie_tl_pkg::axi_resp_t resp;
        reg_write(32'h0000_1020, 32'hDEAD_BEEF, resp);
        check_resp("unmapped bresp", resp, pcie_tl_pkg::RESP_SLVERR);
        read_expect(32'h0000_1020, 32'h0, pcie_tl_pkg::RESP_SLVERR, "unmapped");
        // Status is read only
        write_ok(pcie_tl_pkg::REG_VC_FC_STATUS, 32'h0000_00FF, "vc_fc_status");
        read_expect(pcie_tl_pkg::REG_VC_FC_STATUS, 32'h0, pcie_tl_pkg::RESP_OKAY,
                    "vc_fc_status");
    endtask

    task automatic link_bringup();
        write_ok(pcie_tl_pkg::REG_LINK_CTRL, 32'h1, "link_control");
        dll_vc_up_i <= NUM_VC'(1);  // VC 0 ready before the link
        read_expect(pcie_tl_pkg::REG_VC_FC_STATUS, 32'h0, pcie_tl_pkg::RESP_OKAY,
                    "vc_fc_status training");
        @(posedge aclk);
        linkup_i <= 1'b1;
        for (int v = 0; v < NUM_VC; v++) begin
            @(posedge aclk);
            dll_vc_up_i <= dll_vc_up_i | (NUM_VC'(1) << v);
            read_expect(pcie_tl_pkg::REG_VC_FC_STATUS, 32'((1 << (v + 1)) - 1),
                        pcie_tl_pkg::RESP_OKAY, "vc_fc_status walk");
        end
    endtask

    task automatic dma_transfer(input int len, input logic [31:0] src,
                                input logic [31:0] base, input bit rnd);
        pcie_tl_pkg::cpu_r_t   r;
        pcie_tl_pkg::tlp_hdr_t exp_hdr;
        pcie_tl_pkg::tlp_hdr_t got_hdr;
        int                    n;
        int                    b;
        n = len / 64;
        random_ready <= rnd;
        tx_q.delete();
        write_ok(pcie_tl_pkg::REG_BAR0_BASE, base, "bar0");
        write_ok(pcie_tl_pkg::REG_TX_DESC_LEN, 32'(len), "desc_len");
        write_ok(pcie_tl_pkg::REG_TX_DESC_ADDR, src, "desc_addr");
        write_ok(pcie_tl_pkg::REG_DMA_CFG, 32'h1, "dma_configure");
        reg_read(pcie_tl_pkg::REG_DMA_CFG, r);
        check_word("dma_configure busy", r.data, 32'h1);
        do reg_read(pcie_tl_pkg::REG_DMA_CFG, r); while (r.data[0]);
        check_word("tx word count", 32'(tx_q.size()), 32'(n * 19));
        if (tx_q.size() == n * 19) begin
            for (int k = 0; k < n; k++) begin
                b                = 19 * k;
                exp_hdr          = '0;
                exp_hdr.fmt      = pcie_tl_pkg::FMT_MWR32;
                exp_hdr.typ      = pcie_tl_pkg::TYPE_MEM;
                exp_hdr.length   = 10'd16;
                exp_hdr.tag      = 8'(k);
                exp_hdr.last_be  = 4'hF;
                exp_hdr.first_be = 4'hF;
                exp_hdr.addr     = base + 32'(64 * k);
                got_hdr          = {tx_q[b], tx_q[b + 1], tx_q[b + 2]};
                check_hdr("tlp header", got_hdr, exp_hdr);
                for (int j = 0; j < 16; j++) begin
                    check_word("tlp payload", tx_q[b + 3 + j],
                               mem_word(src + 32'(64 * k + 4 * j)));
                end
            end
        end
        random_ready <= 1'b0;
    endtask

    initial begin
        arst        = 1'b0;
        awvalid_i   = 1'b0;
        wvalid_i    = 1'b0;
        cpu_aw_i    = '0;
        bready_i    = 1'b0;
        arvalid_i   = 1'b0;
        araddr_i    = '0;
        rready_i    = 1'b0;
        linkup_i    = 1'b0;
        dll_vc_up_i = '0;
        repeat (10) @(posedge aclk);
        arst <= 1'b1;
        reg_readback();
        unmapped_access();
        link_bringup();
        dma_transfer(64, 32'h0000_4000, 32'h8000_0000, 1'b0);
        dma_transfer(256, 32'h0001_0040, 32'h9000_0100, 1'b1);
        $display("Checks: %0d  errors: %0d  assertion failures: %0d", checks, errors,
                 dut_i.u_props.fail_count);
        if (errors == 0 && dut_i.u_props.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_pcie_tl_properties.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pcie_tl_properties (
    input wire                           aclk,
    input wire                           arst,
    input wire                           tx_valid_o,
    input wire                           tx_ready_i,
    input wire [pcie_tl_pkg::DATA_W-1:0] tx_data_o,
    input wire                           bvalid_o,
    input wire                           bready_i,
    input wire                           rvalid_o,
    input wire                           rready_i,
    input wire pcie_tl_pkg::cpu_r_t      cpu_r_o,
    input wire                           mem_arvalid_o,
    input wire                           mem_arready_i,
    input wire [pcie_tl_pkg::DATA_W-1:0] mem_araddr_o
);

    int fail_count = 0;  // Read by the testbench top

    // TX word held while the DLL stalls
    a_tx_stable: assert property (@(posedge aclk) disable iff (!arst)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o))
        else begin
            $error("TX word changed under back-pressure");
            fail_count++;
        end

    a_b_hold: assert property (@(posedge aclk) disable iff (!arst)
        bvalid_o && !bready_i |=> bvalid_o)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    a_r_hold: assert property (@(posedge aclk) disable iff (!arst)
        rvalid_o && !rready_i |=> rvalid_o && $stable(cpu_r_o))
        else begin
            $error("Read response dropped or changed before rready");
            fail_count++;
        end

    a_ar_hold: assert property (@(posedge aclk) disable iff (!arst)
        mem_arvalid_o && !mem_arready_i |=> mem_arvalid_o && $stable(mem_araddr_o))
        else begin
            $error("Memory AR dropped or changed before arready");
            fail_count++;
        end

endmodule

bind pcie_tl tb_pcie_tl_properties u_props (.*);

`default_nettype wire

//--- pcie_tl.sv
`timescale 1ns/1ns
`default_nettype none

module pcie_tl #(
    parameter int NUM_VC = 8
) (
    input  wire                               aclk,
    input  wire                               arst,
    // Processor port
    input  wire                               awvalid_i,
    input  wire                               wvalid_i,
    input  wire pcie_tl_pkg::cpu_aw_t         cpu_aw_i,
    output logic                              awready_o,
    output logic                              wready_o,
    output logic                              bvalid_o,
    input  wire                               bready_i,
    output pcie_tl_pkg::axi_resp_t            bresp_o,
    input  wire                               arvalid_i,
    input  wire pcie_tl_pkg::cpu_ar_t         araddr_i,
    output logic                              arready_o,
    output logic                              rvalid_o,
    input  wire                               rready_i,
    output pcie_tl_pkg::cpu_r_t               cpu_r_o,
    // Memory read port
    output logic                              mem_arvalid_o,
    input  wire                               mem_arready_i,
    output logic [pcie_tl_pkg::DATA_W-1:0]    mem_araddr_o,
    input  wire                               mem_rvalid_i,
    output logic                              mem_rready_o,
    input  wire [pcie_tl_pkg::DATA_W-1:0]     mem_rdata_i,
    input  wire                               mem_rlast_i,
    // DLL side
    output logic                              tx_valid_o,
    input  wire                               tx_ready_i,
    output logic [pcie_tl_pkg::DATA_W-1:0]    tx_data_o,
    input  wire                               linkup_i,
    input  wire [NUM_VC-1:0]                  dll_vc_up_i
);

    logic                           link_start;
    logic [NUM_VC-1:0]              vc_up;
    logic                           dma_start;
    logic                           dma_busy;
    pcie_tl_pkg::tx_desc_t          tx_desc;
    logic [pcie_tl_pkg::DATA_W-1:0] bar0;
    logic                           tlp_req_valid;
    logic                           tlp_req_ready;
    pcie_tl_pkg::tlp_req_t          tlp_req;
    logic                           tlp_done;

    pcie_tl_regs #(
        .NUM_VC (NUM_VC)
    ) u_regs (
        .aclk         (aclk),
        .arst         (arst),
        .awvalid_i    (awvalid_i),
        .wvalid_i     (wvalid_i),
        .cpu_aw_i     (cpu_aw_i),
        .awready_o    (awready_o),
        .wready_o     (wready_o),
        .bvalid_o     (bvalid_o),
        .bready_i     (bready_i),
        .bresp_o      (bresp_o),
        .arvalid_i    (arvalid_i),
        .araddr_i     (araddr_i),
        .arready_o    (arready_o),
        .rvalid_o     (rvalid_o),
        .rready_i     (rready_i),
        .cpu_r_o      (cpu_r_o),
        .link_start_o (link_start),
        .vc_up_i      (vc_up),
        .dma_start_o  (dma_start),
        .dma_busy_i   (dma_busy),
        .tx_desc_o    (tx_desc),
        .bar0_o       (bar0)
    );

    pcie_tl_link_init #(
        .NUM_VC (NUM_VC)
    ) u_link_init (
        .aclk         (aclk),
        .arst         (arst),
        .link_start_i (link_start),
        .linkup_i     (linkup_i),
        .dll_vc_up_i  (dll_vc_up_i),
        .vc_up_o      (vc_up)
    );

    pcie_tl_dma_rd u_dma_rd (
        .aclk            (aclk),
        .arst            (arst),
        .dma_start_i     (dma_start),
        .tx_desc_i       (tx_desc),
        .bar0_i          (bar0),
        .tlp_done_i      (tlp_done),
        .dma_busy_o      (dma_busy),
        .mem_arvalid_o   (mem_arvalid_o),
        .mem_arready_i   (mem_arready_i),
        .mem_araddr_o    (mem_araddr_o),
        .tlp_req_valid_o (tlp_req_valid),
        .tlp_req_ready_i (tlp_req_ready),
        .tlp_req_o       (tlp_req)
    );

    pcie_tl_tlp_tx u_tlp_tx (
        .aclk            (aclk),
        .arst            (arst),
        .tlp_req_valid_i (tlp_req_valid),
        .tlp_req_i       (tlp_req),
        .tlp_req_ready_o (tlp_req_ready),
        .tlp_done_o      (tlp_done),
        .mem_rvalid_i    (mem_rvalid_i),
        .mem_rdata_i     (mem_rdata_i),
        .mem_rlast_i     (mem_rlast_i),
        .mem_rready_o    (mem_rready_o),
        .tx_valid_o      (tx_valid_o),
        .tx_data_o       (tx_data_o),
        .tx_ready_i      (tx_ready_i)
    );

endmodule

`default_nettype wire

//--- pcie_tl_tlp_tx.sv
`timescale 1ns/1ns
`default_nettype none

module pcie_tl_tlp_tx (
    input  wire                               aclk,
    input  wire                               arst,
    input  wire                               tlp_req_valid_i,
    input  wire pcie_tl_pkg::tlp_req_t        tlp_req_i,
    output logic                              tlp_req_ready_o,
    output logic                              tlp_done_o,
    input  wire                               mem_rvalid_i,
    input  wire [pcie_tl_pkg::DATA_W-1:0]     mem_rdata_i,
    input  wire                               mem_rlast_i,
    output logic                              mem_rready_o,
    output logic                              tx_valid_o,
    output logic [pcie_tl_pkg::DATA_W-1:0]    tx_data_o,
    input  wire                               tx_ready_i
);

    typedef enum logic [1:0] {S_IDLE, S_HDR, S_PAY} state_t;

    state_t                state_q;
    logic [1:0]            hdr_idx_q;
    pcie_tl_pkg::tlp_hdr_t hdr_d;
    pcie_tl_pkg::tlp_hdr_t hdr_q;
    logic                  last_xfer;

    assign last_xfer       = state_q == S_PAY && mem_rvalid_i && tx_ready_i && mem_rlast_i;
    assign tlp_done_o      = last_xfer;
    assign tlp_req_ready_o = state_q == S_IDLE || last_xfer;  // Back to back TLPs
    assign mem_rready_o    = state_q == S_PAY && tx_ready_i;

    always_comb begin
        hdr_d          = '0;
        hdr_d.fmt      = pcie_tl_pkg::FMT_MWR32;
        hdr_d.typ      = pcie_tl_pkg::TYPE_MEM;
        hdr_d.length   = 10'(pcie_tl_pkg::BURST_BEATS);
        hdr_d.tag      = tlp_req_i.tag;
        hdr_d.last_be  = 4'hF;
        hdr_d.first_be = 4'hF;
        hdr_d.addr     = tlp_req_i.addr;
    end

    always_comb begin
        case (state_q)
            S_HDR: begin
                tx_valid_o = 1'b1;
                tx_data_o  = hdr_q[(2 - hdr_idx_q) * 32 +: 32];  // DW0 first
            end
            S_PAY: begin
                tx_valid_o = mem_rvalid_i;
                tx_data_o  = mem_rdata_i;
            end
            default: begin
                tx_valid_o = 1'b0;
                tx_data_o  = '0;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!arst) begin
            state_q   <= S_IDLE;
            hdr_idx_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (tlp_req_valid_i) begin
                        state_q   <= S_HDR;
                        hdr_idx_q <= '0;
                    end
                end
                S_HDR: begin
                    if (tx_ready_i) begin
                        hdr_idx_q <= hdr_idx_q + 1'b1;
                        if (hdr_idx_q == 2'd2) state_q <= S_PAY;
                    end
                end
                S_PAY: begin
                    if (last_xfer) begin
                        state_q   <= tlp_req_valid_i ? S_HDR : S_IDLE;
                        hdr_idx_q <= '0;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (tlp_req_valid_i && tlp_req_ready_o) hdr_q <= hdr_d;
    end

endmodule

`default_nettype wire

//--- pcie_tl_dma_rd.sv
`timescale 1ns/1ns
`default_nettype none

module pcie_tl_dma_rd (
    input  wire                               aclk,
    input  wire                               arst,
    input  wire                               dma_start_i,
    input  wire pcie_tl_pkg::tx_desc_t        tx_desc_i,
    input  wire [pcie_tl_pkg::DATA_W-1:0]     bar0_i,
    input  wire                               tlp_done_i,
    output logic                              dma_busy_o,
    output logic                              mem_arvalid_o,
    input  wire                               mem_arready_i,
    output logic [pcie_tl_pkg::DATA_W-1:0]    mem_araddr_o,
    output logic                              tlp_req_valid_o,
    input  wire                               tlp_req_ready_i,
    output pcie_tl_pkg::tlp_req_t             tlp_req_o
);

    localparam int SHIFT = $clog2(pcie_tl_pkg::TLP_BYTES);
    localparam int CNT_W = 16 - SHIFT;

    logic [CNT_W-1:0] chunks;
    logic [CNT_W-1:0] issue_left_q;  // Chunks not yet handed off
    logic [CNT_W-1:0] done_left_q;   // TLPs not yet sent
    logic             start_go;
    logic             chunk_go;
    logic             next_chunk;

    assign chunks     = tx_desc_i.len[15:SHIFT];
    assign start_go   = dma_start_i && !dma_busy_o && chunks != '0;
    // Chunk handed off once both AR and request are taken
    assign chunk_go   = (mem_arvalid_o || tlp_req_valid_o) &&
                        (!mem_arvalid_o || mem_arready_i) &&
                        (!tlp_req_valid_o || tlp_req_ready_i);
    assign next_chunk = chunk_go && issue_left_q != CNT_W'(1);

    always_ff @(posedge aclk) begin
        if (!arst) begin
            dma_busy_o      <= 1'b0;
            mem_arvalid_o   <= 1'b0;
            tlp_req_valid_o <= 1'b0;
            issue_left_q    <= '0;
            done_left_q     <= '0;
        end else if (start_go) begin
            dma_busy_o      <= 1'b1;
            mem_arvalid_o   <= 1'b1;
            tlp_req_valid_o <= 1'b1;
            issue_left_q    <= chunks;
            done_left_q     <= chunks;
        end else begin
            if (chunk_go) begin
                issue_left_q    <= issue_left_q - 1'b1;
                mem_arvalid_o   <= next_chunk;
                tlp_req_valid_o <= next_chunk;
            end else begin
                mem_arvalid_o   <= mem_arvalid_o && !mem_arready_i;
                tlp_req_valid_o <= tlp_req_valid_o && !tlp_req_ready_i;
            end
            if (tlp_done_i) begin
                done_left_q <= done_left_q - 1'b1;
                if (done_left_q == CNT_W'(1)) dma_busy_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (start_go) begin
            mem_araddr_o   <= tx_desc_i.addr;
            tlp_req_o.addr <= bar0_i;
            tlp_req_o.tag  <= '0;
        end else if (next_chunk) begin
            mem_araddr_o   <= mem_araddr_o + pcie_tl_pkg::TLP_BYTES;
            tlp_req_o.addr <= tlp_req_o.addr + pcie_tl_pkg::TLP_BYTES;
            tlp_req_o.tag  <= tlp_req_o.tag + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- pcie_tl_link_init.sv
`timescale 1ns/1ns
`default_nettype none

module pcie_tl_link_init #(
    parameter int NUM_VC = 8
) (
    input  wire               aclk,
    input  wire               arst,
    input  wire               link_start_i,
    input  wire               linkup_i,
    input  wire [NUM_VC-1:0]  dll_vc_up_i,
    output logic [NUM_VC-1:0] vc_up_o
);

    localparam int IDX_W = (NUM_VC > 1) ? $clog2(NUM_VC) : 1;

    typedef enum logic [1:0] {L_IDLE, L_TRAIN, L_WALK} state_t;

    state_t           state_q;
    logic [IDX_W-1:0] vc_idx_q;

    always_ff @(posedge aclk) begin
        if (!arst) begin
            state_q  <= L_IDLE;
            vc_idx_q <= '0;
            vc_up_o  <= '0;
        end else begin
            case (state_q)
                L_IDLE: begin
                    if (link_start_i) state_q <= L_TRAIN;
                end
                L_TRAIN: begin
                    if (linkup_i) begin
                        state_q  <= L_WALK;
                        vc_idx_q <= '0;
                    end
                end
                L_WALK: begin
                    // One VC per cycle, strictly in order
                    if (dll_vc_up_i[vc_idx_q]) begin
                        vc_up_o[vc_idx_q] <= 1'b1;
                        if (vc_idx_q == IDX_W'(NUM_VC - 1)) begin
                            state_q <= L_IDLE;
                        end else begin
                            vc_idx_q <= vc_idx_q + 1'b1;
                        end
                    end
                end
                default: state_q <= L_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pcie_tl_regs.sv
`timescale 1ns/1ns
`default_nettype none

module pcie_tl_regs #(
    parameter int NUM_VC = 8
) (
    input  wire                               aclk,
    input  wire                               arst,
    input  wire                               awvalid_i,
    input  wire                               wvalid_i,
    input  wire pcie_tl_pkg::cpu_aw_t         cpu_aw_i,
    output logic                              awready_o,
    output logic                              wready_o,
    output logic                              bvalid_o,
    input  wire                               bready_i,
    output pcie_tl_pkg::axi_resp_t            bresp_o,
    input  wire                               arvalid_i,
    input  wire pcie_tl_pkg::cpu_ar_t         araddr_i,
    output logic                              arready_o,
    output logic                              rvalid_o,
    input  wire                               rready_i,
    output pcie_tl_pkg::cpu_r_t               cpu_r_o,
    output logic                              link_start_o,
    input  wire [NUM_VC-1:0]                  vc_up_i,
    output logic                              dma_start_o,
    input  wire                               dma_busy_i,
    output pcie_tl_pkg::tx_desc_t             tx_desc_o,
    output logic [pcie_tl_pkg::DATA_W-1:0]    bar0_o
);

    logic [pcie_tl_pkg::DATA_W-1:0] tc_vc_map_q;
    logic [pcie_tl_pkg::DATA_W-1:0] link_ctrl_q;
    logic [pcie_tl_pkg::DATA_W-1:0] bar0_q;
    logic [pcie_tl_pkg::DATA_W-1:0] desc_len_q;
    logic [pcie_tl_pkg::DATA_W-1:0] desc_addr_q;
    logic [pcie_tl_pkg::DATA_W-1:0] rd_data;
    logic                           wr_fire;
    logic                           rd_fire;

    function automatic logic is_mapped(input logic [pcie_tl_pkg::DATA_W-1:0] addr);
        return addr inside {pcie_tl_pkg::REG_TC_VC_MAP, pcie_tl_pkg::REG_LINK_CTRL,
                            pcie_tl_pkg::REG_VC_FC_STATUS, pcie_tl_pkg::REG_BAR0_BASE,
                            pcie_tl_pkg::REG_DMA_CFG, pcie_tl_pkg::REG_TX_DESC_LEN,
                            pcie_tl_pkg::REG_TX_DESC_ADDR};
    endfunction

    assign wr_fire  = awready_o && awvalid_i && wvalid_i;
    assign rd_fire  = arready_o && arvalid_i;
    assign wready_o = awready_o;  // AW and W taken together

    always_comb begin
        case (araddr_i.addr)
            pcie_tl_pkg::REG_TC_VC_MAP:    rd_data = tc_vc_map_q;
            pcie_tl_pkg::REG_LINK_CTRL:    rd_data = link_ctrl_q;
            pcie_tl_pkg::REG_VC_FC_STATUS: rd_data = 32'(vc_up_i);
            pcie_tl_pkg::REG_BAR0_BASE:    rd_data = bar0_q;
            pcie_tl_pkg::REG_DMA_CFG:      rd_data = {31'b0, dma_busy_i};
            pcie_tl_pkg::REG_TX_DESC_LEN:  rd_data = desc_len_q;
            pcie_tl_pkg::REG_TX_DESC_ADDR: rd_data = desc_addr_q;
            default:                       rd_data = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!arst) begin
            awready_o    <= 1'b0;
            bvalid_o     <= 1'b0;
            arready_o    <= 1'b0;
            rvalid_o     <= 1'b0;
            link_start_o <= 1'b0;
            dma_start_o  <= 1'b0;
            tc_vc_map_q  <= '0;
            link_ctrl_q  <= '0;
            bar0_q       <= '0;
            desc_len_q   <= '0;
            desc_addr_q  <= '0;
        end else begin
            awready_o <= awvalid_i && wvalid_i && !bvalid_o && !awready_o;
            arready_o <= arvalid_i && !arready_o && !rvalid_o;

            if (wr_fire) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end

            link_start_o <= wr_fire && cpu_aw_i.data[0] &&
                            cpu_aw_i.addr == pcie_tl_pkg::REG_LINK_CTRL;
            dma_start_o  <= wr_fire && cpu_aw_i.data[0] && !dma_busy_i &&
                            cpu_aw_i.addr == pcie_tl_pkg::REG_DMA_CFG;

            if (wr_fire) begin
                case (cpu_aw_i.addr)
                    pcie_tl_pkg::REG_TC_VC_MAP:    tc_vc_map_q <= cpu_aw_i.data;
                    pcie_tl_pkg::REG_LINK_CTRL:    link_ctrl_q <= cpu_aw_i.data;
                    pcie_tl_pkg::REG_BAR0_BASE:    bar0_q      <= cpu_aw_i.data;
                    pcie_tl_pkg::REG_TX_DESC_LEN:  desc_len_q  <= cpu_aw_i.data;
                    pcie_tl_pkg::REG_TX_DESC_ADDR: desc_addr_q <= cpu_aw_i.data;
                    default: ;
                endcase
            end
        end
    end

    // Response payload
    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            bresp_o <= is_mapped(cpu_aw_i.addr) ? pcie_tl_pkg::RESP_OKAY
                                                : pcie_tl_pkg::RESP_SLVERR;
        end
        if (rd_fire) begin
            cpu_r_o.data <= rd_data;
            cpu_r_o.resp <= is_mapped(araddr_i.addr) ? pcie_tl_pkg::RESP_OKAY
                                                     : pcie_tl_pkg::RESP_SLVERR;
        end
    end

    assign tx_desc_o.len  = desc_len_q[15:0];
    assign tx_desc_o.addr = desc_addr_q;
    assign bar0_o         = bar0_q;

endmodule

`default_nettype wire

//--- pcie_tl_pkg.sv
`default_nettype none

package pcie_tl_pkg;

    localparam int DATA_W = 32;

    // Register map
    localparam logic [DATA_W-1:0] REG_TC_VC_MAP    = 32'h0000_1000;
    localparam logic [DATA_W-1:0] REG_LINK_CTRL    = 32'h0000_1004;
    localparam logic [DATA_W-1:0] REG_VC_FC_STATUS = 32'h0000_1008;  // Read only
    localparam logic [DATA_W-1:0] REG_BAR0_BASE    = 32'h0000_100C;
    localparam logic [DATA_W-1:0] REG_DMA_CFG      = 32'h0000_1010;
    localparam logic [DATA_W-1:0] REG_TX_DESC_LEN  = 32'h0000_2000;
    localparam logic [DATA_W-1:0] REG_TX_DESC_ADDR = 32'h0000_2004;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_SLVERR = 2'd2;

    localparam int BURST_BEATS = 16;              // DWs per TLP and per burst
    localparam int TLP_BYTES   = BURST_BEATS * 4;

    localparam logic [2:0] FMT_MWR32 = 3'b010;    // 3DW header with data
    localparam logic [4:0] TYPE_MEM  = 5'b00000;

    typedef struct packed {
        logic [DATA_W-1:0] addr;
    } cpu_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } cpu_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        axi_resp_t         resp;
    } cpu_r_t;

    typedef struct packed {
        logic [15:0]       len;                   // Bytes
        logic [DATA_W-1:0] addr;
    } tx_desc_t;

    typedef struct packed {
        logic [DATA_W-1:0] addr;
        logic [7:0]        tag;
    } tlp_req_t;

    // MemWr header, DW0 in the upper word
    typedef struct packed {
        logic [2:0]        fmt;
        logic [4:0]        typ;
        logic [13:0]       rsvd;                  // TC, attr, TD, EP, AT
        logic [9:0]        length;
        logic [15:0]       req_id;
        logic [7:0]        tag;
        logic [3:0]        last_be;
        logic [3:0]        first_be;
        logic [DATA_W-1:0] addr;
    } tlp_hdr_t;

endpackage

`default_nettype wire
